// File: fpga_regmap_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Register map, bus widths, identification value and motor command word
////////////////////////////////////////////////////////////////////////////
package fpga_regmap_pkg;

    parameter int REG_ADDR_W = 6;                                // SPI frame address bits
    parameter int REG_DATA_W = 8;                                // Register width

    // Banks of four, one register per motor
    parameter logic [REG_ADDR_W-1:0] ADDR_DRIVE_CMD0 = 6'h00;   // Drive UART command, r/w
    parameter logic [REG_ADDR_W-1:0] ADDR_ROT_CTRL0  = 6'h04;   // Rotation levels, r/w
    parameter logic [REG_ADDR_W-1:0] ADDR_ROT_PWM0   = 6'h08;   // Rotation PWM ratio, r/w
    parameter logic [REG_ADDR_W-1:0] ADDR_SERVO_POS0 = 6'h10;   // Servo PWM ratio, r/w

    // Single registers
    parameter logic [REG_ADDR_W-1:0] ADDR_FAULT      = 6'h20;   // Synced faults, read only
    parameter logic [REG_ADDR_W-1:0] ADDR_LED_TEST   = 6'h21;   // LED override, r/w
    parameter logic [REG_ADDR_W-1:0] ADDR_ID         = 6'h3F;   // Identification, read only

    parameter int LED_TEST_EN = 4;                               // Override enable bit
    parameter logic [REG_DATA_W-1:0] SUBSYS_ID = 8'h5A;

    // Command byte, sent raw on the UART or decoded into levels
    typedef union packed {
        logic [REG_DATA_W-1:0] raw;                              // Bus and UART view
        struct packed {
            logic       brake;                                   // Bit 7
            logic       enable;                                  // Bit 6
            logic       direction;                               // Bit 5
            logic [4:0] speed;                                   // Drive motors only
        } f;
    } motor_cmd_u;

endpackage

// File: motor_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Motor counts, PWM width and UART frame constants
////////////////////////////////////////////////////////////////////////////
package motor_pkg;

    parameter int NUM_MOTORS       = 4;     // Motors of each kind
    parameter int PWM_W            = 8;     // Period is 2**PWM_W clocks
    parameter int UART_FRAME_BITS  = 10;    // Start, 8 data, stop
    parameter int DEFAULT_BAUD_DIV = 116;   // Clocks per bit, 115200 baud

endpackage

// File: reg_bus_if.sv
////////////////////////////////////////////////////////////////////////////
// Register bus between the SPI target and the register file
////////////////////////////////////////////////////////////////////////////
interface reg_bus_if import fpga_regmap_pkg::*; ();

    logic [REG_ADDR_W-1:0] addr;      // Held for the whole frame
    logic                  wr_en;     // One clock per write
    logic [REG_DATA_W-1:0] wr_data;   // Valid with wr_en
    logic [REG_DATA_W-1:0] rd_data;   // Combinational decode of addr

    modport target (output addr, output wr_en, output wr_data, input rd_data);
    modport regs   (input addr, input wr_en, input wr_data, output rd_data);

endinterface

// File: spi_target.sv
////////////////////////////////////////////////////////////////////////////
// SPI mode 0 target, two-byte frames to register bus reads and writes
////////////////////////////////////////////////////////////////////////////
module spi_target import fpga_regmap_pkg::*; (
    input  logic      clock,        // System clock
    input  logic      rst_n,        // Async reset, active low
    input  logic      spi_clock,    // SPI clock pin
    input  logic      cs_n,         // Chip select pin
    input  logic      mosi,         // Serial data in
    output logic      miso,         // Serial data out
    reg_bus_if.target bus           // Register bus
);

    logic [2:0]            sclk_s;     // Two sync flops plus edge history
    logic [1:0]            cs_s;       // Chip select sync
    logic [1:0]            mosi_s;     // Data sync, aligned with sclk_s[1]
    logic                  sclk_rise;
    logic                  sclk_fall;
    logic                  cs_hi;      // Synced deselect
    logic [4:0]            bit_cnt;    // Rising edges seen, 0 to 16
    logic [REG_DATA_W-1:0] rx_q;       // Receive shifter
    logic [REG_DATA_W-1:0] rx_next;
    logic [REG_DATA_W-1:0] tx_q;       // Read value shifter
    logic [REG_ADDR_W-1:0] addr_q;     // Frame address
    logic                  wr_flag_q;  // Command bit 7
    logic                  load_q;     // Capture rd_data next clock
    logic                  wr_en_q;
    logic                  miso_q;
    logic                  tx_phase;   // Second byte on miso

    assign sclk_rise = sclk_s[1] & ~sclk_s[2];
    assign sclk_fall = ~sclk_s[1] & sclk_s[2];
    assign cs_hi     = cs_s[1];
    assign rx_next   = {rx_q[REG_DATA_W-2:0], mosi_s[1]};   // MSB first
    assign tx_phase  = sclk_fall && (bit_cnt >= 5'd8);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            sclk_s <= '0;
            cs_s   <= '1;                                    // Deselected
            mosi_s <= '0;
        end else begin
            sclk_s <= {sclk_s[1:0], spi_clock};
            cs_s   <= {cs_s[0], cs_n};
            mosi_s <= {mosi_s[0], mosi};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame control
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt   <= '0;
            addr_q    <= '0;
            wr_flag_q <= 1'b0;
            load_q    <= 1'b0;
            wr_en_q   <= 1'b0;
            miso_q    <= 1'b0;
        end else begin
            load_q  <= 1'b0;
            wr_en_q <= 1'b0;
            if (cs_hi) begin
                bit_cnt <= '0;                               // Early deselect drops frame
                miso_q  <= 1'b0;
            end else begin
                if (sclk_rise && bit_cnt != 5'd16) begin
                    bit_cnt <= bit_cnt + 5'd1;
                    if (bit_cnt == 5'd7) begin               // Command byte complete
                        addr_q    <= rx_next[REG_ADDR_W-1:0];
                        wr_flag_q <= rx_next[7];
                        load_q    <= ~rx_next[7];
                    end
                    if (bit_cnt == 5'd15)
                        wr_en_q <= wr_flag_q;                // Data byte complete
                end
                if (tx_phase)
                    miso_q <= tx_q[REG_DATA_W-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sclk_rise)
            rx_q <= rx_next;
        if (load_q)
            tx_q <= bus.rd_data;                             // Read value captured
        else if (tx_phase)
            tx_q <= {tx_q[REG_DATA_W-2:0], 1'b0};
    end

    assign bus.addr    = addr_q;
    assign bus.wr_en   = wr_en_q;
    assign bus.wr_data = rx_q;
    assign miso        = miso_q & ~cs_n;                     // Quiet when deselected

    a_wr_selected: assert property (@(posedge clock) disable iff (!rst_n)
        bus.wr_en |-> !cs_hi);
    a_wr_single: assert property (@(posedge clock) disable iff (!rst_n)
        bus.wr_en |=> !bus.wr_en);

endmodule

// File: reg_file.sv
////////////////////////////////////////////////////////////////////////////
// Register file, address decode, fault sync and status LEDs
////////////////////////////////////////////////////////////////////////////
module reg_file import fpga_regmap_pkg::*, motor_pkg::*; (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic [NUM_MOTORS-1:0] sr_fault,                 // Async fault pins
    reg_bus_if.regs               bus,
    output motor_cmd_u            drive_cmd [NUM_MOTORS-1:0],   // To UARTs
    output logic [PWM_W-1:0]      rot_pwm [NUM_MOTORS-1:0],     // Rotation ratios
    output logic [PWM_W-1:0]      servo_pos [NUM_MOTORS-1:0],   // Servo ratios
    output logic [NUM_MOTORS-1:0] sr_brake,
    output logic [NUM_MOTORS-1:0] sr_enable,
    output logic [NUM_MOTORS-1:0] sr_direction,
    output logic                  status_fault,
    output logic                  status_pi,
    output logic                  status_ps4,
    output logic                  status_debug
);

    motor_cmd_u            rot_ctrl_q [NUM_MOTORS-1:0];
    logic [REG_DATA_W-1:0] led_test_q;
    logic [NUM_MOTORS-1:0] fault_meta_q;                     // First sync stage
    logic [NUM_MOTORS-1:0] fault_q;
    logic [1:0]            idx;                              // Motor within a bank
    logic [REG_ADDR_W-3:0] bank;

    assign idx  = bus.addr[1:0];
    assign bank = bus.addr[REG_ADDR_W-1:2];

    ////////////////////////////////////////////////////////////////////////////
    // Writes
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_MOTORS; i++) begin
                drive_cmd[i]  <= '0;
                rot_ctrl_q[i] <= '0;
                rot_pwm[i]    <= '0;
                servo_pos[i]  <= '0;
            end
            led_test_q <= '0;
        end else if (bus.wr_en) begin
            if (bus.addr == ADDR_LED_TEST)
                led_test_q <= bus.wr_data;                   // All bits kept
            else begin
                case (bank)
                    ADDR_DRIVE_CMD0[REG_ADDR_W-1:2]: drive_cmd[idx].raw  <= bus.wr_data;
                    ADDR_ROT_CTRL0[REG_ADDR_W-1:2]:  rot_ctrl_q[idx].raw <= bus.wr_data;
                    ADDR_ROT_PWM0[REG_ADDR_W-1:2]:   rot_pwm[idx]        <= bus.wr_data;
                    ADDR_SERVO_POS0[REG_ADDR_W-1:2]: servo_pos[idx]      <= bus.wr_data;
                    default: ;                               // Read only or unmapped
                endcase
            end
        end
    end

    // Reads, unmapped return zero
    always_comb begin
        bus.rd_data = '0;
        case (bank)
            ADDR_DRIVE_CMD0[REG_ADDR_W-1:2]: bus.rd_data = drive_cmd[idx].raw;
            ADDR_ROT_CTRL0[REG_ADDR_W-1:2]:  bus.rd_data = rot_ctrl_q[idx].raw;
            ADDR_ROT_PWM0[REG_ADDR_W-1:2]:   bus.rd_data = rot_pwm[idx];
            ADDR_SERVO_POS0[REG_ADDR_W-1:2]: bus.rd_data = servo_pos[idx];
            default: begin
                if (bus.addr == ADDR_FAULT)
                    bus.rd_data = {{(REG_DATA_W-NUM_MOTORS){1'b0}}, fault_q};
                else if (bus.addr == ADDR_LED_TEST)
                    bus.rd_data = led_test_q;
                else if (bus.addr == ADDR_ID)
                    bus.rd_data = SUBSYS_ID;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Faults and outputs
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fault_meta_q <= '0;
            fault_q      <= '0;
        end else begin
            fault_meta_q <= sr_fault;
            fault_q      <= fault_meta_q;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_MOTORS; i++) begin
            sr_brake[i]     = rot_ctrl_q[i].f.brake;
            sr_enable[i]    = rot_ctrl_q[i].f.enable;
            sr_direction[i] = rot_ctrl_q[i].f.direction;     // Speed bits unused here
        end
    end

    assign status_fault = led_test_q[LED_TEST_EN] ? led_test_q[0] : |fault_q;
    assign status_pi    = led_test_q[LED_TEST_EN] & led_test_q[1];
    assign status_ps4   = led_test_q[LED_TEST_EN] & led_test_q[2];
    assign status_debug = led_test_q[LED_TEST_EN] & led_test_q[3];

    a_fault_sync: assert property (@(posedge clock) disable iff (!rst_n)
        $past(rst_n, 2) |-> fault_q == $past(sr_fault, 2));

endmodule

// File: uart_tx.sv
////////////////////////////////////////////////////////////////////////////
// Continuous 8N1 transmitter for one drive motor command byte
////////////////////////////////////////////////////////////////////////////
module uart_tx import fpga_regmap_pkg::*, motor_pkg::*; #(
    parameter int BAUD_DIV = DEFAULT_BAUD_DIV                // Clocks per bit
) (
    input  logic       clock,
    input  logic       rst_n,
    input  motor_cmd_u cmd,                                  // Current command
    output logic       tx                                    // Serial line, idles high
);

    localparam int BAUD_W = $clog2(BAUD_DIV);
    localparam int IDX_W  = $clog2(UART_FRAME_BITS);

    logic [BAUD_W-1:0]     baud_cnt;
    logic [IDX_W-1:0]      bit_idx;                          // Bit now on the line
    logic [REG_DATA_W-1:0] shift_q;
    logic                  tick;                             // End of a bit period
    logic                  frame_end;

    assign tick      = (baud_cnt == BAUD_W'(BAUD_DIV - 1));
    assign frame_end = (bit_idx == IDX_W'(UART_FRAME_BITS - 1));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            baud_cnt <= '0;
            bit_idx  <= IDX_W'(UART_FRAME_BITS - 1);         // One stop-length idle
            tx       <= 1'b1;
        end else if (tick) begin
            baud_cnt <= '0;
            if (frame_end) begin
                bit_idx <= '0;
                tx      <= 1'b0;                             // Start bit
            end else begin
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == IDX_W'(UART_FRAME_BITS - 2))
                    tx <= 1'b1;                              // Stop bit
                else
                    tx <= shift_q[0];                        // LSB first
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (tick && frame_end)
            shift_q <= cmd.raw;                              // Latch at start bit
        else if (tick)
            shift_q <= shift_q >> 1;
    end

    a_idx_range: assert property (@(posedge clock) disable iff (!rst_n)
        bit_idx < IDX_W'(UART_FRAME_BITS));

endmodule

// File: pwm_gen.sv
////////////////////////////////////////////////////////////////////////////
// PWM generator, ratio loaded at the period boundary
////////////////////////////////////////////////////////////////////////////
module pwm_gen import motor_pkg::*; (
    input  logic             clock,
    input  logic             rst_n,
    input  logic [PWM_W-1:0] ratio,                          // High clocks per period
    output logic             pwm
);

    logic [PWM_W-1:0] cnt_q;                                 // Free running
    logic [PWM_W-1:0] ratio_q;                               // Active ratio
    logic [PWM_W-1:0] cnt_next;
    logic [PWM_W-1:0] ratio_next;

    assign cnt_next   = cnt_q + 1'b1;
    assign ratio_next = (cnt_q == '1) ? ratio : ratio_q;     // Load on wrap

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q   <= '0;
            ratio_q <= '0;
            pwm     <= 1'b0;
        end else begin
            cnt_q   <= cnt_next;
            ratio_q <= ratio_next;
            pwm     <= (cnt_next < ratio_next);              // High while below ratio
        end
    end

    a_zero_low: assert property (@(posedge clock) disable iff (!rst_n)
        (ratio_q == '0) |-> !pwm);

endmodule

// File: fpga_subsystem.sv
////////////////////////////////////////////////////////////////////////////
// Motor I/O core top level, SPI registers, drive UARTs and PWMs
////////////////////////////////////////////////////////////////////////////
module fpga_subsystem import fpga_regmap_pkg::*, motor_pkg::*; #(
    parameter int BAUD_DIV = DEFAULT_BAUD_DIV                // Drive UART clocks per bit
) (
    input  logic                  clock,                     // Main clock
    input  logic                  rst_n,                     // Async reset, active low
    input  logic                  spi_clock,                 // SPI mode 0
    input  logic                  cs_n,
    input  logic                  mosi,
    output logic                  miso,
    input  logic [NUM_MOTORS-1:0] sr_fault,                  // From rotation drivers
    output logic [NUM_MOTORS-1:0] sr_pwm,
    output logic [NUM_MOTORS-1:0] sr_direction,
    output logic [NUM_MOTORS-1:0] sr_enable,
    output logic [NUM_MOTORS-1:0] sr_brake,
    output logic [NUM_MOTORS-1:0] sd_uart,                   // Drive motor commands
    output logic [NUM_MOTORS-1:0] servo_pwm,                 // Arm servos
    output logic                  status_fault,              // LEDs
    output logic                  status_pi,
    output logic                  status_ps4,
    output logic                  status_debug
);

    motor_cmd_u       drive_cmd [NUM_MOTORS-1:0];
    logic [PWM_W-1:0] rot_pwm [NUM_MOTORS-1:0];
    logic [PWM_W-1:0] servo_pos [NUM_MOTORS-1:0];

    reg_bus_if bus_if ();

    spi_target spi_target_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .spi_clock (spi_clock),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .miso      (miso),
        .bus       (bus_if.target)
    );

    reg_file reg_file_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .sr_fault     (sr_fault),
        .bus          (bus_if.regs),
        .drive_cmd    (drive_cmd),
        .rot_pwm      (rot_pwm),
        .servo_pos    (servo_pos),
        .sr_brake     (sr_brake),
        .sr_enable    (sr_enable),
        .sr_direction (sr_direction),
        .status_fault (status_fault),
        .status_pi    (status_pi),
        .status_ps4   (status_ps4),
        .status_debug (status_debug)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Per-motor outputs
    ////////////////////////////////////////////////////////////////////////////
    for (genvar m = 0; m < NUM_MOTORS; m++) begin : g_motor
        uart_tx #(.BAUD_DIV(BAUD_DIV)) uart_tx_i (
            .clock (clock),
            .rst_n (rst_n),
            .cmd   (drive_cmd[m]),
            .tx    (sd_uart[m])
        );

        pwm_gen rot_pwm_i (
            .clock (clock),
            .rst_n (rst_n),
            .ratio (rot_pwm[m]),
            .pwm   (sr_pwm[m])
        );

        pwm_gen servo_pwm_i (
            .clock (clock),
            .rst_n (rst_n),
            .ratio (servo_pos[m]),
            .pwm   (servo_pwm[m])
        );
    end

endmodule

// File: tb_fpga_subsystem.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the motor I/O core with LFSR stimulus, SPI driver,
// register model and LED, PWM and UART output checkers
////////////////////////////////////////////////////////////////////////////
module tb_fpga_subsystem;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 100;
    localparam int BAUD        = 16;                         // Clocks per UART bit
    localparam int SPI_HALF    = 4;                          // Clocks per SPI half period
    localparam int FRAME_CLKS  = 2 * SPI_HALF * 16 + 3 * SPI_HALF;
    localparam int REG_OPS     = 60;
    localparam int FAULT_RUNS  = 8;
    localparam int ROT_RUNS    = 8;
    localparam int PWM_RUNS    = 8;
    localparam int PWM_WAIT    = 600;
    localparam int UART_RUNS   = 6;
    localparam int SPI_FRAMES  = REG_OPS + 4 * FAULT_RUNS + 1 + ROT_RUNS + PWM_RUNS + UART_RUNS;
    localparam int UART_FRAMES = 4 * UART_RUNS;              // Up to four frames per run
    localparam int WATCHDOG_CLKS = 2 * (SPI_FRAMES * FRAME_CLKS + UART_FRAMES * 10 * BAUD
                                        + PWM_RUNS * (PWM_WAIT + 256));
    localparam logic [5:0] A_FAULT = 6'h20;
    localparam logic [5:0] A_LED   = 6'h21;
    localparam logic [5:0] A_ID    = 6'h3F;

    logic       clock;
    logic       rst_n;
    logic       spi_clock;
    logic       cs_n;
    logic       mosi;
    logic       miso;
    logic [3:0] sr_fault;
    logic [3:0] sr_pwm;
    logic [3:0] sr_direction;
    logic [3:0] sr_enable;
    logic [3:0] sr_brake;
    logic [3:0] sd_uart;
    logic [3:0] servo_pwm;
    logic       status_fault;
    logic       status_pi;
    logic       status_ps4;
    logic       status_debug;

    logic [31:0] lfsr_state;
    logic [7:0]  model [64];                                 // Register model by address
    logic [3:0]  fault_model;
    int          checks;
    int          errors;
    int          rx_count [4];                               // Frames received per motor
    logic [7:0]  rx_byte [4];                                // Last received byte

    fpga_subsystem #(.BAUD_DIV(BAUD)) fpga_subsystem_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .spi_clock    (spi_clock),
        .cs_n         (cs_n),
        .mosi         (mosi),
        .miso         (miso),
        .sr_fault     (sr_fault),
        .sr_pwm       (sr_pwm),
        .sr_direction (sr_direction),
        .sr_enable    (sr_enable),
        .sr_brake     (sr_brake),
        .sd_uart      (sd_uart),
        .servo_pwm    (servo_pwm),
        .status_fault (status_fault),
        .status_pi    (status_pi),
        .status_ps4   (status_ps4),
        .status_debug (status_debug)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_CLKS * CLK_PERIOD);
        $display("Watchdog expired after %0d clocks, tests did not finish", WATCHDOG_CLKS);
        $display("Checks %0d, errors %0d", checks, errors);
        $display("*** FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};       // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);               // One step per bit
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clock);
        #10;                                                 // Drive point after the edge
    endtask

    function automatic logic is_rw(input logic [5:0] a);
        return (a <= 6'h0B) || (a >= 6'h10 && a <= 6'h13) || (a == A_LED);
    endfunction

    function automatic logic [7:0] model_read(input logic [5:0] a);
        if (a == A_FAULT)
            return {4'h0, fault_model};
        if (a == A_ID)
            return 8'h5A;
        return is_rw(a) ? model[a] : 8'h00;                  // Unmapped reads zero
    endfunction

    // One two-byte frame that also collects the miso bits of the second byte
    task automatic spi_frame(input logic wr, input logic [5:0] a, input logic [7:0] data,
                             output logic [7:0] rdata);
        logic [15:0] word;
        word  = {wr, 1'b0, a, data};
        rdata = '0;
        cs_n  = 1'b0;
        wait_clocks(SPI_HALF);
        for (int i = 15; i >= 0; i--) begin
            mosi = word[i];                                  // MSB first
            wait_clocks(SPI_HALF);
            if (i < 8)
                rdata = {rdata[6:0], miso};                  // Sampled before rising edge
            spi_clock = 1'b1;
            wait_clocks(SPI_HALF);
            spi_clock = 1'b0;
        end
        wait_clocks(SPI_HALF);
        cs_n = 1'b1;
        mosi = 1'b0;
        wait_clocks(SPI_HALF);
    endtask

    task automatic reg_access(input logic wr, input logic [5:0] a, input logic [7:0] data);
        logic [7:0] got;
        logic [7:0] exp;
        spi_frame(wr, a, data, got);
        if (wr) begin
            if (is_rw(a))
                model[a] = data;                             // Read-only and unmapped ignored
        end else begin
            exp = model_read(a);
            checks++;
            if (got !== exp) begin
                errors++;
                $display("Fail miso addr %h exp %h got %h", a, exp, got);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic test_reg_access();
        logic [4:0] r;
        logic [5:0] a;
        for (int i = 0; i < REG_OPS; i++) begin
            r = rand_bits(5);
            if (r < 12)
                a = 6'(r);                                   // Drive, rotation banks
            else if (r < 16)
                a = 6'h10 + 6'(r - 12);                      // Servo bank
            else if (r < 18)
                a = A_FAULT;
            else if (r < 20)
                a = A_LED;
            else if (r < 22)
                a = A_ID;
            else
                a = {2'b11, r[3:0]};                         // Mostly unmapped
            case (i)
                0: reg_access(1'b1, A_FAULT, 8'hFF);
                1: reg_access(1'b0, A_FAULT, 8'h00);
                2: reg_access(1'b1, A_ID, 8'h00);
                3: reg_access(1'b0, A_ID, 8'h00);
                4: reg_access(1'b0, 6'h0C, 8'h00);
                default: reg_access(rand_bits(1), a, rand_bits(8));
            endcase
        end
    endtask

    task automatic test_faults();
        logic [3:0] f;
        logic [7:0] d;
        logic [3:0] leds;
        reg_access(1'b1, A_LED, 8'h00);
        for (int i = 0; i < FAULT_RUNS; i++) begin
            f           = rand_bits(4);
            sr_fault    = f;
            fault_model = f;
            wait_clocks(4);
            reg_access(1'b0, A_FAULT, 8'h00);
            leds = {status_debug, status_ps4, status_pi, status_fault};
            checks++;
            if (leds !== {3'b000, |f}) begin
                errors++;
                $display("Fail status_leds exp %h got %h", {3'b000, |f}, leds);
            end
            d = {3'(rand_bits(3)), 1'b1, 4'(rand_bits(4))};  // Test enable set
            reg_access(1'b1, A_LED, d);
            wait_clocks(2);
            leds = {status_debug, status_ps4, status_pi, status_fault};
            checks++;
            if (leds !== d[3:0]) begin
                errors++;
                $display("Fail status_leds exp %h got %h", d[3:0], leds);
            end
            reg_access(1'b0, A_LED, 8'h00);                  // Upper bits read back
            reg_access(1'b1, A_LED, 8'h00);
        end
    endtask

    task automatic test_rot_ctrl();
        logic [11:0] exp;
        logic [11:0] got;
        for (int i = 0; i < ROT_RUNS; i++) begin
            reg_access(1'b1, 6'h04 + 6'(rand_bits(2)), rand_bits(8));
            wait_clocks(8);
            for (int k = 0; k < 4; k++) begin
                exp[k]     = model[6'h04 + k][7];            // Brake
                exp[k + 4] = model[6'h04 + k][6];            // Enable
                exp[k + 8] = model[6'h04 + k][5];            // Direction
            end
            got = {sr_direction, sr_enable, sr_brake};
            checks++;
            if (got !== exp) begin
                errors++;
                $display("Fail sr_direction_enable_brake exp %h got %h", exp, got);
            end
        end
    endtask

    task automatic test_pwm();
        logic [7:0] ratio;
        logic       servo;
        int         m;
        int         hi;
        for (int i = 0; i < PWM_RUNS; i++) begin
            ratio = (i == 0) ? 8'h00 : (i == 1) ? 8'hFF : 8'(rand_bits(8));
            servo = rand_bits(1);
            m     = rand_bits(2);
            reg_access(1'b1, (servo ? 6'h10 : 6'h08) + 6'(m), ratio);
            wait_clocks(PWM_WAIT);                           // New ratio surely loaded
            hi = 0;
            for (int c = 0; c < 256; c++) begin
                wait_clocks(1);
                if (servo ? servo_pwm[m] : sr_pwm[m])
                    hi++;
            end
            checks++;
            if (hi != ratio) begin
                errors++;
                $display("Fail %s[%0d] exp %h got %h", servo ? "servo_pwm" : "sr_pwm",
                         m, ratio, hi);
            end
        end
    endtask

    task automatic test_uart();
        logic [7:0] old;
        logic [7:0] d;
        int         m;
        int         n0;
        for (int i = 0; i < UART_RUNS; i++) begin
            m   = rand_bits(2);
            d   = rand_bits(8);
            old = model[m];
            reg_access(1'b1, 6'(m), d);
            n0 = rx_count[m];
            for (int f = 1; f <= 3; f++) begin
                while (rx_count[m] == n0 + f - 1)
                    wait_clocks(1);
                checks++;
                if ((f == 1) ? (rx_byte[m] !== old && rx_byte[m] !== d) : (rx_byte[m] !== d)) begin
                    errors++;
                    $display("Fail sd_uart[%0d] exp %h got %h", m, d, rx_byte[m]);
                end
            end
        end
    endtask

    // UART receivers sample mid-bit in step with the frames since reset
    for (genvar g = 0; g < 4; g++) begin : g_rx
        initial begin
            logic [7:0] b;
            rx_count[g] = 0;
            rx_byte[g]  = '0;
            @(posedge rst_n);
            forever begin
                @(negedge clock);
                if (sd_uart[g] == 1'b0) begin
                    repeat (BAUD / 2) @(negedge clock);      // Middle of start bit
                    if (sd_uart[g] !== 1'b0) begin
                        errors++;
                        $display("Fail sd_uart[%0d] start bit exp 0 got %h", g, sd_uart[g]);
                    end
                    for (int k = 0; k < 8; k++) begin
                        repeat (BAUD) @(negedge clock);
                        b = {sd_uart[g], b[7:1]};            // LSB first
                    end
                    repeat (BAUD) @(negedge clock);
                    if (sd_uart[g] !== 1'b1) begin
                        errors++;
                        $display("Fail sd_uart[%0d] stop bit exp 1 got %h", g, sd_uart[g]);
                    end
                    rx_byte[g]  = b;
                    rx_count[g] = rx_count[g] + 1;
                end
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        spi_clock   = 1'b0;
        cs_n        = 1'b1;
        mosi        = 1'b0;
        sr_fault    = 4'h0;
        fault_model = 4'h0;
        lfsr_state  = 32'hb8bd;
        checks      = 0;
        errors      = 0;
        for (int a = 0; a < 64; a++)
            model[a] = 8'h00;                                // Reset values
        wait_clocks(2);
        rst_n = 1'b1;
        wait_clocks(2);
        test_reg_access();
        test_faults();
        test_rot_ctrl();
        test_pwm();
        test_uart();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: fpga_subsystem.f
fpga_regmap_pkg.sv
motor_pkg.sv
reg_bus_if.sv
spi_target.sv
reg_file.sv
uart_tx.sv
pwm_gen.sv
fpga_subsystem.sv
tb_fpga_subsystem.sv
